// File: logic/pixel_pkg.sv
package pixel_pkg;

	// *************************************************************************
	// Tile geometry and value widths
	// *************************************************************************
	localparam int tile_rows = 32;
	localparam int tile_cols = 32;

	typedef logic [15:0] chan_t;     // One colour channel or one luma value
	typedef logic [4:0]  coord_t;    // Row or column inside the tile
	typedef logic [1:0]  chan_sel_t;

	localparam chan_sel_t chan_red   = 2'd0;
	localparam chan_sel_t chan_green = 2'd1;
	localparam chan_sel_t chan_blue  = 2'd2;
	localparam chan_sel_t chan_luma  = 2'd3;

	typedef struct packed {
		chan_t red;
		chan_t green;
		chan_t blue;
	} pixel_t;

	// Same layout as the low 12 bits of a tile address on the bus
	typedef struct packed {
		chan_sel_t chan;
		coord_t    row;
		coord_t    col;
	} mem_addr_t;

	// *************************************************************************
	// Host bus
	// *************************************************************************
	typedef logic [12:0] wb_adr_t;

	localparam int adr_ctrl_bit = 12;    // High selects the control register

	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		wb_adr_t adr;
		chan_t   dat;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		chan_t dat;
	} wb_rsp_t;

	localparam int ctrl_start_bit  = 0;
	localparam int status_busy_bit = 0;
	localparam int status_done_bit = 1;

	typedef enum logic {eng_idle, eng_sweep} engine_state_t;

endpackage

// File: logic/local_mem_pixel.sv
`timescale 1ns/1ps

module local_mem_pixel (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 read_pixel_signal,
	input  logic                 write_pixel_signal,
	input  pixel_pkg::mem_addr_t pixel_addr,
	input  pixel_pkg::chan_t     write_pixel_data,
	output pixel_pkg::pixel_t    read_pixel_data
);

	pixel_pkg::pixel_t pixel_mem [pixel_pkg::tile_rows][pixel_pkg::tile_cols];
	pixel_pkg::coord_t row;
	pixel_pkg::coord_t col;

	assign row = pixel_addr.row;
	assign col = pixel_addr.col;

	// *************************************************************************
	// Write one channel of the addressed pixel
	// *************************************************************************
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int r = 0; r < pixel_pkg::tile_rows; r++)
			begin
				for (int c = 0; c < pixel_pkg::tile_cols; c++)
				begin
					pixel_mem[r][c] <= '0;
				end
			end
		end
		else if (write_pixel_signal)
		begin
			case (pixel_addr.chan)
				pixel_pkg::chan_red:
				begin
					pixel_mem[row][col].red <= write_pixel_data;
				end
				pixel_pkg::chan_green:
				begin
					pixel_mem[row][col].green <= write_pixel_data;
				end
				pixel_pkg::chan_blue:
				begin
					pixel_mem[row][col].blue <= write_pixel_data;
				end
				default:
				begin
					// Luma code has no storage here
				end
			endcase
		end
	end

	// *************************************************************************
	// Whole-pixel read
	// *************************************************************************
	always_comb
	begin
		if (read_pixel_signal)
		begin
			read_pixel_data = pixel_mem[row][col];
		end
		else
		begin
			read_pixel_data = '0;    // Bus stays quiet between reads
		end
	end

endmodule

// File: logic/luma_buffer.sv
`timescale 1ns/1ps

module luma_buffer (
	input  logic              clk,
	input  logic              rst,
	input  logic              write_luma,
	input  pixel_pkg::coord_t write_row,
	input  pixel_pkg::coord_t write_col,
	input  pixel_pkg::chan_t  write_data,
	input  pixel_pkg::coord_t read_row,
	input  pixel_pkg::coord_t read_col,
	output pixel_pkg::chan_t  read_data
);

	pixel_pkg::chan_t luma_mem [pixel_pkg::tile_rows][pixel_pkg::tile_cols];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int r = 0; r < pixel_pkg::tile_rows; r++)
			begin
				for (int c = 0; c < pixel_pkg::tile_cols; c++)
				begin
					luma_mem[r][c] <= '0;
				end
			end
		end
		else if (write_luma)
		begin
			luma_mem[write_row][write_col] <= write_data;    // Engine side
		end
	end

	// Host side sees the entry in the same cycle
	assign read_data = luma_mem[read_row][read_col];

endmodule

// File: logic/luma_engine.sv
`timescale 1ns/1ps

module luma_engine (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  pixel_pkg::pixel_t        pixel,
	output logic                     busy,
	output pixel_pkg::coord_t        row,
	output pixel_pkg::coord_t        col,
	output logic                     write_luma,
	output pixel_pkg::chan_t         luma
);

	pixel_pkg::engine_state_t state;
	logic [9:0]  pix_idx;     // Raster position, row in the upper half
	logic [17:0] luma_sum;

	// *************************************************************************
	// Sweep control
	// *************************************************************************
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state   <= pixel_pkg::eng_idle;
			pix_idx <= '0;
		end
		else
		begin
			case (state)
				pixel_pkg::eng_idle:
				begin
					if (start)
					begin
						state   <= pixel_pkg::eng_sweep;
						pix_idx <= '0;
					end
				end
				pixel_pkg::eng_sweep:
				begin
					pix_idx <= pix_idx + 10'd1;
					if (pix_idx == '1)
					begin
						state <= pixel_pkg::eng_idle;    // Last pixel of the tile
					end
				end
				default:
				begin
					state <= pixel_pkg::eng_idle;
				end
			endcase
		end
	end

	assign busy       = (state == pixel_pkg::eng_sweep);
	assign write_luma = busy;
	assign row        = pix_idx[9:5];
	assign col        = pix_idx[4:0];

	// *************************************************************************
	// Luma datapath
	// *************************************************************************
	// Two guard bits keep the carry of r + 2g + b
	always_comb
	begin
		luma_sum = {2'b00, pixel.red} + {1'b0, pixel.green, 1'b0} + {2'b00, pixel.blue};
	end

	assign luma = luma_sum[17:2];    // Divide by four, truncating

endmodule

// File: logic/wb_pixel_port.sv
`timescale 1ns/1ps

module wb_pixel_port (
	input  logic                 clk,
	input  logic                 rst,
	input  pixel_pkg::wb_req_t   wb_req,
	output pixel_pkg::wb_rsp_t   wb_rsp,
	input  logic                 busy,
	input  pixel_pkg::coord_t    eng_row,
	input  pixel_pkg::coord_t    eng_col,
	output logic                 start,
	output pixel_pkg::mem_addr_t mem_addr,
	output logic                 mem_write,
	output pixel_pkg::chan_t     mem_wdata,
	output logic                 mem_read,
	input  pixel_pkg::pixel_t    mem_rdata,
	output pixel_pkg::coord_t    luma_row,
	output pixel_pkg::coord_t    luma_col,
	input  pixel_pkg::chan_t     luma_rdata
);

	pixel_pkg::mem_addr_t bus_addr;
	pixel_pkg::chan_t     status_word;
	pixel_pkg::chan_t     chan_word;
	pixel_pkg::chan_t     rd_word;
	pixel_pkg::chan_t     rdata_q;
	logic                 ack_q;
	logic                 done;
	logic                 ctrl_sel;
	logic                 stall;
	logic                 accept;
	logic                 start_req;
	logic                 last_pixel;

	// *************************************************************************
	// Decode and handshake
	// *************************************************************************
	assign bus_addr = pixel_pkg::mem_addr_t'(wb_req.adr[11:0]);
	assign ctrl_sel = wb_req.adr[pixel_pkg::adr_ctrl_bit];
	assign stall    = busy & ~ctrl_sel;    // Tile belongs to the engine while busy

	// The ack cycle itself never counts as a new request
	assign accept    = wb_req.cyc & wb_req.stb & ~ack_q & ~stall;
	assign start_req = accept & wb_req.we & ctrl_sel & wb_req.dat[pixel_pkg::ctrl_start_bit]
		& ~busy;
	assign last_pixel = busy
		& (eng_row == pixel_pkg::coord_t'(pixel_pkg::tile_rows - 1))
		& (eng_col == pixel_pkg::coord_t'(pixel_pkg::tile_cols - 1));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			ack_q <= 1'b0;
			start <= 1'b0;
			done  <= 1'b0;
		end
		else
		begin
			ack_q <= accept;
			start <= start_req;
			if (start_req)
				done <= 1'b0;
			else if (last_pixel)
				done <= 1'b1;    // Same edge where busy drops
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			rdata_q <= rd_word;
	end

	assign wb_rsp = '{ack: ack_q, dat: rdata_q};

	// *************************************************************************
	// Memory side
	// *************************************************************************
	always_comb
	begin
		if (busy)
			mem_addr = '{chan: pixel_pkg::chan_red, row: eng_row, col: eng_col};
		else
			mem_addr = bus_addr;
	end

	assign mem_write = accept & wb_req.we & ~ctrl_sel;
	assign mem_wdata = wb_req.dat;
	assign mem_read  = busy | (accept & ~wb_req.we & ~ctrl_sel);
	assign luma_row  = bus_addr.row;
	assign luma_col  = bus_addr.col;

	// Read word for the ack cycle
	always_comb
	begin
		status_word = '0;
		status_word[pixel_pkg::status_busy_bit] = busy;
		status_word[pixel_pkg::status_done_bit] = done;
		case (bus_addr.chan)
			pixel_pkg::chan_red:   chan_word = mem_rdata.red;
			pixel_pkg::chan_green: chan_word = mem_rdata.green;
			pixel_pkg::chan_blue:  chan_word = mem_rdata.blue;
			default:               chan_word = luma_rdata;
		endcase
		rd_word = ctrl_sel ? status_word : chan_word;
	end

endmodule

// File: logic/pixel_tile_top.sv
`timescale 1ns/1ps

module pixel_tile_top (
	input  logic               clk,
	input  logic               rst,
	input  pixel_pkg::wb_req_t wb_req,
	output pixel_pkg::wb_rsp_t wb_rsp
);

	pixel_pkg::mem_addr_t mem_addr;
	pixel_pkg::pixel_t    mem_rdata;
	pixel_pkg::chan_t     mem_wdata;
	pixel_pkg::chan_t     luma_rdata;
	pixel_pkg::chan_t     luma;
	pixel_pkg::coord_t    eng_row;
	pixel_pkg::coord_t    eng_col;
	pixel_pkg::coord_t    luma_row;
	pixel_pkg::coord_t    luma_col;
	logic                 mem_write;
	logic                 mem_read;
	logic                 busy;
	logic                 start;
	logic                 write_luma;

	wb_pixel_port i_wb_pixel_port (
		.clk        (clk),
		.rst        (rst),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.busy       (busy),
		.eng_row    (eng_row),
		.eng_col    (eng_col),
		.start      (start),
		.mem_addr   (mem_addr),
		.mem_write  (mem_write),
		.mem_wdata  (mem_wdata),
		.mem_read   (mem_read),
		.mem_rdata  (mem_rdata),
		.luma_row   (luma_row),
		.luma_col   (luma_col),
		.luma_rdata (luma_rdata)
	);

	local_mem_pixel i_local_mem_pixel (
		.clk                (clk),
		.rst                (rst),
		.read_pixel_signal  (mem_read),
		.write_pixel_signal (mem_write),
		.pixel_addr         (mem_addr),
		.write_pixel_data   (mem_wdata),
		.read_pixel_data    (mem_rdata)
	);

	luma_engine i_luma_engine (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.pixel      (mem_rdata),
		.busy       (busy),
		.row        (eng_row),
		.col        (eng_col),
		.write_luma (write_luma),
		.luma       (luma)
	);

	luma_buffer i_luma_buffer (
		.clk        (clk),
		.rst        (rst),
		.write_luma (write_luma),
		.write_row  (eng_row),
		.write_col  (eng_col),
		.write_data (luma),
		.read_row   (luma_row),
		.read_col   (luma_col),
		.read_data  (luma_rdata)
	);

endmodule

// File: test/pixel_tile_asserts.sv
`timescale 1ns/1ps

module pixel_tile_asserts (
	input logic               clk,
	input logic               rst,
	input pixel_pkg::wb_req_t wb_req,
	input pixel_pkg::wb_rsp_t wb_rsp,
	input logic               busy,
	input logic               done
);

	logic [10:0] busy_len;    // Length of the current or the last sweep

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			busy_len <= '0;
		else
			busy_len <= busy ? busy_len + 11'd1 : '0;
	end

	// *************************************************************************
	// Bus handshake
	// *************************************************************************
	ack_needs_request: assert property (@(posedge clk) disable iff (rst)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
		else $error("Ack seen without cyc and stb from the host");

	ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
		wb_rsp.ack |=> !wb_rsp.ack)
		else $error("Ack stayed high for two cycles");

	no_tile_ack_busy: assert property (@(posedge clk) disable iff (rst)
		(wb_rsp.ack && !wb_req.adr[pixel_pkg::adr_ctrl_bit]) |-> !busy)
		else $error("Tile access acknowledged while the engine was busy");

	ack_low_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> !wb_rsp.ack)
		else $error("Ack high right after reset");

	// *************************************************************************
	// Engine timing
	// *************************************************************************
	sweep_length: assert property (@(posedge clk) disable iff (rst)
		$fell(busy) |-> (busy_len == 11'd1024))
		else $error("Busy did not last 1024 cycles");

	done_on_busy_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(busy) |-> $rose(done))
		else $error("Done did not rise when busy fell");

endmodule

bind pixel_tile_top pixel_tile_asserts i_pixel_tile_asserts (
	.clk    (clk),
	.rst    (rst),
	.wb_req (wb_req),
	.wb_rsp (wb_rsp),
	.busy   (busy),
	.done   (i_wb_pixel_port.done)
);

// File: test/pixel_tile_tb.sv
`timescale 1ns/1ps

module pixel_tile_tb;

	localparam int drive_delay  = 1;
	localparam int ack_timeout  = 2000;    // Long enough for a tile access stalled by a sweep
	localparam int poll_timeout = 1000;
	localparam pixel_pkg::wb_adr_t ctrl_adr = 13'h1000;

	logic               clk = 1'b0;
	logic               rst;
	pixel_pkg::wb_req_t wb_req;
	pixel_pkg::wb_rsp_t wb_rsp;
	logic [15:0]        lfsr = 16'd22;
	pixel_pkg::chan_t   model_chan [3][32][32];    // Red, green, blue as the host wrote them
	pixel_pkg::chan_t   model_luma [32][32];

	pixel_tile_top i_pixel_tile_top (.clk(clk), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp));

	always #50 clk = ~clk;

	// *************************************************************************
	// Stimulus helpers
	// *************************************************************************
	// Fibonacci taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic random_pixel(output int r, output int c);
		logic [15:0] v;
		random_bits(5, v);
		r = int'(v);
		random_bits(5, v);
		c = int'(v);
	endtask

	function automatic pixel_pkg::wb_adr_t tile_adr(input int ch, input int r, input int c);
		return {1'b0, 2'(ch), 5'(r), 5'(c)};
	endfunction

	// Luma rule of the accelerator: (red + 2 green + blue) / 4, truncated
	function automatic pixel_pkg::chan_t luma_of(input int r, input int c);
		int sum;
		sum = int'(model_chan[0][r][c]) + 2 * int'(model_chan[1][r][c])
			+ int'(model_chan[2][r][c]);
		return pixel_pkg::chan_t'(sum / 4);
	endfunction

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	// *************************************************************************
	// Wishbone classic master
	// *************************************************************************
	// Called a drive delay after a rising edge, and returns at the same point
	task automatic bus_cycle(input logic we, input pixel_pkg::wb_adr_t adr,
		input pixel_pkg::chan_t dat, output pixel_pkg::chan_t rdata);
		int waited;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		waited = 0;
		do
		begin
			@(posedge clk);
			#drive_delay;
			waited++;
			if (waited > ack_timeout)
			begin
				$display("Timeout at %0t: no ack for bus address %h", $time, adr);
				stop_run();
			end
		end
		while (!wb_rsp.ack);
		rdata = wb_rsp.dat;
		@(posedge clk);    // Request stays up through the ack cycle
		#drive_delay;
		wb_req = '0;
	endtask

	task automatic write_chan(input int ch, input int r, input int c, input pixel_pkg::chan_t v);
		pixel_pkg::chan_t ignored;
		bus_cycle(1'b1, tile_adr(ch, r, c), v, ignored);
		if (ch < 3)
			model_chan[ch][r][c] = v;
	endtask

	task automatic check_read(input pixel_pkg::wb_adr_t adr, input pixel_pkg::chan_t exp);
		pixel_pkg::chan_t got;
		bus_cycle(1'b0, adr, '0, got);
		assert (got === exp)
		else
		begin
			$display("ERR %0t: read at %h returned %h, expected %h", $time, adr, got, exp);
			stop_run();
		end
	endtask

	task automatic check_pixel(input int r, input int c);
		for (int ch = 0; ch < 3; ch++)
			check_read(tile_adr(ch, r, c), model_chan[ch][r][c]);
		check_read(tile_adr(3, r, c), model_luma[r][c]);
	endtask

	task automatic check_all_luma();
		foreach (model_luma[r, c])
			check_read(tile_adr(3, r, c), model_luma[r][c]);
	endtask

	task automatic start_engine();
		pixel_pkg::chan_t ignored;
		bus_cycle(1'b1, ctrl_adr, 16'h0001, ignored);
		foreach (model_luma[r, c])
			model_luma[r][c] = luma_of(r, c);
	endtask

	task automatic wait_for_done();
		pixel_pkg::chan_t status;
		int polls;
		polls = 0;
		do
		begin
			if (polls == poll_timeout)
			begin
				$display("Timeout: engine not done after %0d status polls", polls);
				stop_run();
			end
			polls++;
			bus_cycle(1'b0, ctrl_adr, '0, status);
		end
		while (!status[pixel_pkg::status_done_bit]);
	endtask

	// *************************************************************************
	// Test sequence
	// *************************************************************************
	initial
	begin
		logic [15:0] v;
		int r;
		int c;
		int ch;
		rst = 1'b1;
		wb_req = '0;
		foreach (model_luma[i, j])
		begin
			model_luma[i][j] = '0;
			for (int k = 0; k < 3; k++)
				model_chan[k][i][j] = '0;
		end
		repeat (3) @(posedge clk);
		#drive_delay;
		rst = 1'b0;

		// Both memories and the status word come out of reset cleared
		check_read(ctrl_adr, 16'h0000);
		repeat (4)
		begin
			random_pixel(r, c);
			check_pixel(r, c);
		end

		repeat (4)
		begin
			random_pixel(r, c);
			for (ch = 0; ch < 3; ch++)
			begin
				random_bits(16, v);
				write_chan(ch, r, c, v);
			end
			check_pixel(r, c);
			random_bits(2, v);
			ch = int'(v) % 3;
			random_bits(16, v);
			write_chan(ch, r, c, v);
			check_pixel(r, c);
			random_bits(16, v);
			write_chan(3, r, c, v);    // Luma entries are not writable from the bus
			check_pixel(r, c);
		end

		for (r = 0; r < 32; r++)
			for (c = 0; c < 32; c++)
				for (ch = 0; ch < 3; ch++)
				begin
					random_bits(16, v);
					write_chan(ch, r, c, v);
				end
		start_engine();
		check_read(ctrl_adr, 16'h0001);
		wait_for_done();
		check_read(ctrl_adr, 16'h0002);
		check_all_luma();

		repeat (3)
		begin
			random_pixel(r, c);
			for (ch = 0; ch < 3; ch++)
			begin
				random_bits(16, v);
				write_chan(ch, r, c, v);
			end
		end
		start_engine();
		check_read(ctrl_adr, 16'h0001);    // Done cleared by the new start
		check_read(tile_adr(3, r, c), model_luma[r][c]);    // Held until the sweep ends
		check_read(ctrl_adr, 16'h0002);
		check_all_luma();

		$display("Simulation passed");
		$finish;
	end

endmodule

// File: project.f
logic/pixel_pkg.sv
logic/local_mem_pixel.sv
logic/luma_buffer.sv
logic/luma_engine.sv
logic/wb_pixel_port.sv
logic/pixel_tile_top.sv
test/pixel_tile_asserts.sv
test/pixel_tile_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= pixel_tile_tb
OBJ_DIR   ?= obj_dir
FILE_LIST ?= project.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
